//--- dv/rcv_testdata.txt
# V hhhh valid halfword   I idle   C comma   W clear   E end of test
# R hhhhhhhh data read and expected word   S o cc status read and expected overflow and count
# test 1 even block
V 1111
V 2222
V 3333
V 4444
S 0 02
R 22221111
R 44443333
S 0 00
E
# test 2 odd block closed by a comma
V aaaa
V bbbb
V cccc
I
I
S 0 01
C
S 0 02
R bbbbaaaa
R 7fffcccc
S 0 00
E
# test 3 overflow after 15 words
V 3000
V 3001
V 3002
V 3003
V 3004
V 3005
V 3006
V 3007
V 3008
V 3009
V 300a
V 300b
V 300c
V 300d
V 300e
V 300f
V 3010
V 3011
V 3012
V 3013
V 3014
V 3015
V 3016
V 3017
V 3018
V 3019
V 301a
V 301b
V 301c
V 301d
V 301e
V 301f
S 1 0f
R 30013000
R 30033002
R 30053004
R 30073006
R 30093008
R 300b300a
R 300d300c
R 300f300e
R 30113010
R 30133012
R 30153014
R 30173016
R 30193018
R 301b301a
R 301d301c
S 1 00
E
# test 4 clear drops overflow and a held halfword
W
S 0 00
V 5555
W
V 6666
V 7777
S 0 01
R 77776666
S 0 00
E
# test 5 empty read shows the slot at the read pointer
R 301b301a
S 0 00
V 8888
V 9999
S 0 01
R 99998888
S 0 00
E

//--- list.f
hdl/rcv_pkg.sv
hdl/halfword_packer.sv
hdl/rcv_buffer.sv
hdl/rcv_bus_regs.sv
hdl/rcv_top.sv
dv/rcv_tb.sv

//--- Makefile
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  make test   build rcv_tb with Verilator, run it, check $(LOG)"
	@echo "  make clean  remove obj_dir and $(LOG)"
	@echo "  make help   show this list"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module rcv_tb -f list.f -Mdir obj_dir -o rcv_sim
	./obj_dir/rcv_sim | tee $(LOG)
	@grep -q "All checks passed" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf obj_dir $(LOG)

//--- dv/rcv_tb.sv
`default_nettype none

module rcv_tb import rcv_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	localparam string DATA_FILE = "dv/rcv_testdata.txt";
	localparam int CLK_HALF = 5;
	localparam int CLK_PERIOD = 10;
	localparam int RESET_CYCLES = 10;
	localparam int CYCLES_PER_CMD = 20;
	localparam int ACK_WAIT = 8;

	logic gtp_clk = 1'b0;
	logic reset;
	half_t gtp_dat;
	logic gtp_vld;
	logic wb_cyc;
	logic wb_stb;
	logic wb_we;
	logic wb_adr;
	logic wb_ack;
	word_t wb_dat_o;
	count_t fifocnt;
	logic overflow;

	// Idle data and gap placement
	integer seed = 32'hffcc3853;

	// Command lines in the stimulus file, sizes the watchdog
	int n_cmds = 0;

	int n_tests;
	int n_checks;
	int n_errors;
	int test_errors;

	rcv_top UUT (
		.gtp_clk(gtp_clk),
		.reset(reset),
		.gtp_dat(gtp_dat),
		.gtp_vld(gtp_vld),
		.wb_cyc(wb_cyc),
		.wb_stb(wb_stb),
		.wb_we(wb_we),
		.wb_adr(wb_adr),
		.wb_ack(wb_ack),
		.wb_dat_o(wb_dat_o),
		.fifocnt(fifocnt),
		.overflow(overflow)
	);

	always #(CLK_HALF) gtp_clk = ~gtp_clk;

	////////////////////
	// Compare tasks
	////////////////////

	task automatic check_word(input string name, input word_t got, input word_t exp);
		n_checks++;
		if (got !== exp) begin
			$display("** Error: %s = %h, expected %h", name, got, exp);
			n_errors++;
			test_errors++;
		end
	endtask

	task automatic check_count(input string name, input logic got_ovf, input count_t got_cnt,
			input logic exp_ovf, input count_t exp_cnt);
		n_checks++;
		if (got_ovf !== exp_ovf || got_cnt !== exp_cnt) begin
			$display("** Error: %s overflow/count = %h/%h, expected %h/%h",
				name, got_ovf, got_cnt, exp_ovf, exp_cnt);
			n_errors++;
			test_errors++;
		end
	endtask

	////////////////////
	// Link driving
	////////////////////

	// One link cycle, inputs already 1 ns past the edge
	task automatic link_cycle(input half_t dat, input logic vld);
		gtp_dat = dat;
		gtp_vld = vld;
		@(posedge gtp_clk);
		#1;
	endtask

	task automatic idle_cycle();
		half_t dat;
		dat = half_t'($random(seed));
		// Idle data never looks like a comma
		if (dat == COMMA) begin
			dat = ~dat;
		end
		link_cycle(dat, 1'b0);
	endtask

	// Occasional extra idle between link commands
	task automatic random_gap();
		if (($random(seed) & 3) == 0) begin
			idle_cycle();
		end
	endtask

	////////////////////
	// Bus access
	////////////////////

	task automatic bus_access(input logic we, input logic adr, output logic acked,
			output word_t data);
		int waits;
		// Lets the last push reach the memory
		idle_cycle();
		idle_cycle();
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_we = we;
		wb_adr = adr;
		@(posedge gtp_clk);
		#1;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_adr = 1'b0;
		waits = 0;
		while (!wb_ack && waits < ACK_WAIT) begin
			@(posedge gtp_clk);
			#1;
			waits++;
		end
		acked = wb_ack;
		data = wb_dat_o;
		n_checks++;
		if (!acked) begin
			$display("bus access with we=%0b adr=%0b got no acknowledge", we, adr);
			n_errors++;
			test_errors++;
		end
		// Pop or clear lands one cycle after the ack
		idle_cycle();
	endtask

	task automatic end_test();
		n_tests++;
		if (test_errors == 0) begin
			$display("test %0d ok", n_tests);
		end else begin
			$display("test %0d: %0d errors", n_tests, test_errors);
		end
		test_errors = 0;
	endtask

	////////////////////
	// Stimulus file
	////////////////////

	// First pass, commands only
	task automatic count_commands(output int n);
		int fd;
		int r;
		logic [7:0] tok;
		logic [31:0] a;
		logic [31:0] b;
		logic [8*128-1:0] line;
		n = -1;
		fd = $fopen(DATA_FILE, "r");
		if (fd != 0) begin
			n = 0;
			while ($fscanf(fd, "%s", tok) == 1) begin
				if (tok == "#") begin
					r = $fgets(line, fd);
				end else if (tok == "V" || tok == "R") begin
					r = $fscanf(fd, "%h", a);
					n++;
				end else if (tok == "S") begin
					r = $fscanf(fd, "%h %h", a, b);
					n++;
				end else begin
					n++;
				end
			end
			$fclose(fd);
		end
	endtask

	task automatic run_commands();
		int fd;
		int r;
		logic [7:0] tok;
		logic [31:0] a;
		logic [31:0] b;
		logic [8*128-1:0] line;
		logic acked;
		word_t data;
		fd = $fopen(DATA_FILE, "r");
		while ($fscanf(fd, "%s", tok) == 1) begin
			case (tok)
				"#": r = $fgets(line, fd);
				"V": begin
					r = $fscanf(fd, "%h", a);
					link_cycle(a[15:0], 1'b1);
					random_gap();
				end
				"I": idle_cycle();
				"C": begin
					link_cycle(COMMA, 1'b0);
					random_gap();
				end
				"R": begin
					r = $fscanf(fd, "%h", a);
					bus_access(1'b0, 1'b0, acked, data);
					if (acked) begin
						check_word("wb_dat_o", data, word_t'(a));
					end
				end
				"S": begin
					r = $fscanf(fd, "%h %h", a, b);
					bus_access(1'b0, 1'b1, acked, data);
					if (acked) begin
						check_count("status", data[WORD_BITS-1], data[DEPTH_BITS-1:0],
							a[0], count_t'(b));
					end
					// Side outputs mirror the buffer
					check_count("overflow/fifocnt", overflow, fifocnt, a[0], count_t'(b));
				end
				"W": begin
					bus_access(1'b1, 1'b0, acked, data);
					if (acked) begin
						check_word("wb_dat_o", data, '0);
					end
				end
				"E": end_test();
				default: begin
					$display("unknown command %c in the stimulus file", tok);
					n_errors++;
				end
			endcase
		end
		$fclose(fd);
	endtask

	////////////////////
	// Main sequence
	////////////////////

	initial begin
		int n;
		reset = 1'b1;
		gtp_dat = '0;
		gtp_vld = 1'b0;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_adr = 1'b0;
		n_tests = 0;
		n_checks = 0;
		n_errors = 0;
		test_errors = 0;
		count_commands(n);
		if (n < 0) begin
			$display("cannot open the stimulus file %s", DATA_FILE);
			$display("Checks failed");
			$finish;
		end else begin
			n_cmds = n;
			repeat (RESET_CYCLES) @(posedge gtp_clk);
			#1;
			reset = 1'b0;
			run_commands();
			$display("tests %0d, checks %0d, errors %0d", n_tests, n_checks, n_errors);
			if (n_errors == 0) begin
				$display("All checks passed");
			end else begin
				$display("Checks failed");
			end
			$finish;
		end
	end

	// Watchdog sized from reset and the command count
	initial begin
		wait (n_cmds > 0);
		#(CLK_PERIOD * (RESET_CYCLES + CYCLES_PER_CMD * n_cmds));
		$display("watchdog expired before the stimulus file was done");
		$display("Checks failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- hdl/rcv_top.sv
`default_nettype none

module rcv_top import rcv_pkg::*; (
	input wire gtp_clk,
	input wire reset,
	// Transceiver side
	input wire half_t gtp_dat,
	input wire gtp_vld,
	// Bus side
	input wire wb_cyc,
	input wire wb_stb,
	input wire wb_we,
	input wire wb_adr,
	output logic wb_ack,
	output word_t wb_dat_o,
	// Buffer status mirrors
	output count_t fifocnt,
	output logic overflow
);

	// Packer to buffer
	logic push;
	word_t push_word;

	// Bus slave to buffer
	logic pop;
	logic clear;

	// Buffer to bus slave
	word_t head_word;

	////////////////////
	// Link packing
	////////////////////

	halfword_packer u_packer (
		.gtp_clk(gtp_clk),
		.reset(reset),
		.clear(clear),
		.gtp_dat(gtp_dat),
		.gtp_vld(gtp_vld),
		.push(push),
		.push_word(push_word)
	);

	////////////////////
	// Word buffer
	////////////////////

	// Count and overflow go straight out as well
	rcv_buffer u_buffer (
		.gtp_clk(gtp_clk),
		.reset(reset),
		.push(push),
		.push_word(push_word),
		.pop(pop),
		.clear(clear),
		.head_word(head_word),
		.count(fifocnt),
		.overflow(overflow)
	);

	////////////////////
	// Bus slave
	////////////////////

	rcv_bus_regs u_bus_regs (
		.gtp_clk(gtp_clk),
		.reset(reset),
		.wb_cyc(wb_cyc),
		.wb_stb(wb_stb),
		.wb_we(wb_we),
		.wb_adr(wb_adr),
		.head_word(head_word),
		.count(fifocnt),
		.overflow(overflow),
		.wb_ack(wb_ack),
		.wb_dat_o(wb_dat_o),
		.pop(pop),
		.clear(clear)
	);

endmodule

`default_nettype wire

//--- hdl/rcv_bus_regs.sv
`default_nettype none

module rcv_bus_regs import rcv_pkg::*; (
	input wire gtp_clk,
	input wire reset,
	input wire wb_cyc,
	input wire wb_stb,
	input wire wb_we,
	input wire wb_adr,
	input wire word_t head_word,
	input wire count_t count,
	input wire overflow,
	output logic wb_ack,
	output word_t wb_dat_o,
	output logic pop,
	output logic clear
);

	// One cycle bus access
	logic access;

	// Decoded access kinds
	logic rd_data;
	logic rd_status;
	logic wr_any;

	// Overflow on top, fill count at the bottom
	word_t status_word;

	////////////////////
	// Decode
	////////////////////

	assign access = wb_cyc && wb_stb;

	// Address 0 pops the head word
	assign rd_data = access && !wb_we && !wb_adr;

	// Address 1 is status
	assign rd_status = access && !wb_we && wb_adr;

	// Any write clears, address ignored
	assign wr_any = access && wb_we;

	assign status_word = {overflow, {STATUS_PAD{1'b0}}, count};

	////////////////////
	// Control
	////////////////////

	// Ack, pop and clear all land on the cycle after the access
	always_ff @(posedge gtp_clk) begin
		if (reset) begin
			wb_ack <= 1'b0;
			pop <= 1'b0;
			clear <= 1'b0;
		end else begin
			wb_ack <= access;
			pop <= rd_data;
			clear <= wr_any;
		end
	end

	// Read data latched with the ack
	always_ff @(posedge gtp_clk) begin
		if (rd_data) begin
			// Head word as it stands, even when empty
			wb_dat_o <= head_word;
		end else if (rd_status) begin
			wb_dat_o <= status_word;
		end else if (wr_any) begin
			// Write returns zero
			wb_dat_o <= '0;
		end
	end

	////////////////////
	// Checks
	////////////////////

	// Every access is answered on the next cycle
	ack_follows_access: assert property (
		@(posedge gtp_clk) disable iff (reset)
		access |=> wb_ack
	);

endmodule

`default_nettype wire

//--- hdl/rcv_buffer.sv
`default_nettype none

module rcv_buffer import rcv_pkg::*; (
	input wire gtp_clk,
	input wire reset,
	input wire push,
	input wire word_t push_word,
	input wire pop,
	input wire clear,
	output word_t head_word,
	output count_t count,
	output logic overflow
);

	// Word storage
	word_t mem [DEPTH];

	// Next slot to write and current head
	ptr_t wr_ptr;
	ptr_t rd_ptr;

	// Write pointer one step ahead
	ptr_t wr_next;

	logic full;
	logic empty;

	// Requests that actually move a pointer
	logic push_ok;
	logic pop_ok;

	////////////////////
	// Flags
	////////////////////

	assign wr_next = wr_ptr + 1'b1;

	// Full leaves one slot unused
	assign full = (wr_next == rd_ptr);
	assign empty = (wr_ptr == rd_ptr);

	// Clear wins over both requests
	// After an overflow every push is dropped until clear
	assign push_ok = push && !full && !overflow && !clear;
	assign pop_ok = pop && !empty && !clear;

	////////////////////
	// Pointers
	////////////////////

	always_ff @(posedge gtp_clk) begin
		if (reset || clear) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (push_ok) begin
				wr_ptr <= wr_next;
			end
			// Pop on empty is ignored
			if (pop_ok) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
		end
	end

	// Sticky until clear
	always_ff @(posedge gtp_clk) begin
		if (reset || clear) begin
			overflow <= 1'b0;
		end else if (push && (full || overflow)) begin
			overflow <= 1'b1;
		end
	end

	////////////////////
	// Memory
	////////////////////

	// Write lands in the cycle the push is seen
	always_ff @(posedge gtp_clk) begin
		if (push_ok) begin
			mem[wr_ptr] <= push_word;
		end
	end

	// Head word shown without a read strobe
	assign head_word = mem[rd_ptr];

	// Fill count follows the pointers, one cycle after a push or pop
	assign count = wr_ptr - rd_ptr;

	////////////////////
	// Checks
	////////////////////

	// Full buffer saturates and never wraps to a small count
	count_saturates: assert property (
		@(posedge gtp_clk) disable iff (reset)
		(count == count_t'(MAX_COUNT)) && !pop && !clear |=> count == count_t'(MAX_COUNT)
	);

	// A push in the clear cycle must not survive
	clear_empties: assert property (
		@(posedge gtp_clk) disable iff (reset)
		clear |=> (count == '0) && !overflow
	);

	// Read pointer never runs past the write pointer
	no_underrun: assert property (
		@(posedge gtp_clk) disable iff (reset)
		(count == '0) |=> (count <= count_t'(1))
	);

endmodule

`default_nettype wire

//--- hdl/halfword_packer.sv
`default_nettype none

module halfword_packer import rcv_pkg::*; (
	input wire gtp_clk,
	input wire reset,
	input wire clear,
	input wire half_t gtp_dat,
	input wire gtp_vld,
	output logic push,
	output word_t push_word
);

	// Current half of the word being built
	pack_state_t state;

	// Low halfword waiting for its partner
	half_t hold;

	// Comma seen on the link, only counts without valid
	logic comma;

	// Word completes this cycle
	logic word_done;

	assign comma = !gtp_vld && (gtp_dat == COMMA);

	// Second valid halfword or a comma closing an odd block
	assign word_done = (state == PACK_ODD) && (gtp_vld || comma);

	////////////////////
	// State and push
	////////////////////

	always_ff @(posedge gtp_clk) begin
		if (reset) begin
			state <= PACK_EVEN;
			push <= 1'b0;
		end else begin
			// Push is a single cycle pulse
			push <= 1'b0;
			if (clear) begin
				// Drop any held low halfword
				state <= PACK_EVEN;
			end else begin
				case (state)
					PACK_EVEN: begin
						// Idle and comma leave the state alone
						if (gtp_vld) begin
							state <= PACK_ODD;
						end
					end
					PACK_ODD: begin
						if (word_done) begin
							push <= 1'b1;
							state <= PACK_EVEN;
						end
					end
					default: begin
						state <= PACK_EVEN;
					end
				endcase
			end
		end
	end

	////////////////////
	// Data path
	////////////////////

	always_ff @(posedge gtp_clk) begin
		// Capture the low half
		if (state == PACK_EVEN && gtp_vld) begin
			hold <= gtp_dat;
		end
		// High half is new data or the pad
		if (word_done) begin
			push_word <= {gtp_vld ? gtp_dat : FILL_HALF, hold};
		end
	end

	// At most one word every two link cycles
	push_single_cycle: assert property (
		@(posedge gtp_clk) disable iff (reset)
		push |=> !push
	);

endmodule

`default_nettype wire

//--- hdl/rcv_pkg.sv
`default_nettype none

package rcv_pkg;

	////////////////////
	// Widths
	////////////////////

	// One transceiver halfword per gtp_clk
	localparam int HALF_BITS = 16;

	// Packed word and bus data width
	localparam int WORD_BITS = 32;

	// Buffer address width
	localparam int DEPTH_BITS = 4;

	// Number of memory slots
	localparam int DEPTH = 2 ** DEPTH_BITS;

	// One slot stays empty to tell full from empty
	localparam int MAX_COUNT = DEPTH - 1;

	// Zero bits between overflow and count in the status word
	localparam int STATUS_PAD = WORD_BITS - 1 - DEPTH_BITS;

	////////////////////
	// Types
	////////////////////

	typedef logic [HALF_BITS-1:0] half_t;
	typedef logic [WORD_BITS-1:0] word_t;
	typedef logic [DEPTH_BITS-1:0] ptr_t;
	typedef logic [DEPTH_BITS-1:0] count_t;

	// Packer position inside the current word
	typedef enum logic {
		PACK_EVEN,
		PACK_ODD
	} pack_state_t;

	////////////////////
	// Link characters
	////////////////////

	// K28.5 comma, ends a block
	localparam half_t COMMA = 16'h00BC;

	// Pad for the high half of an odd block end
	localparam half_t FILL_HALF = 16'h7FFF;

endpackage

`default_nettype wire
